/* source/tilePkg.sv */
package tilePkg;

    //====================================================================
    // Fabric identifiers
    //====================================================================
    typedef logic [7:0] tTileId;                 // Top byte of a fabric address

    localparam int TileIdMsb = 31;               // Tile id field
    localparam int TileIdLsb = 24;
    localparam int OffsetMsb = 23;               // Offset inside the tile

    // Transaction kind on the fabric
    typedef enum logic [1:0] {
        Rd    = 2'd0,                            // Read request
        Wr    = 2'd1,                            // Full-word write request
        RdRsp = 2'd2                             // Read response
    } tOpcode;

    //====================================================================
    // Fabric transaction
    //====================================================================
    typedef struct packed {
        logic [31:0] address;                    // {tile id, offset}
        logic [31:0] data;                       // Write data or read data
        tOpcode      opcode;
        tTileId      requestorId;                // Tile that sent it
    } tTileTrans;

    //====================================================================
    // Memory regions
    //====================================================================
    // Region lives in offset bits 23:22
    localparam int RegionMsb = 23;
    localparam int RegionLsb = 22;

    typedef logic [RegionMsb-RegionLsb:0] tRegion;

    localparam tRegion IMemRegion = 2'd0;        // Instruction memory
    localparam tRegion DMemRegion = 2'd1;        // Data memory
    // Values 2 and 3 are unmapped and read back as zero

endpackage

/* source/dualPortRam.sv */
`timescale 1ns/1ps

// Two independent read/write ports on one word array
module dualPortRam #(
    parameter int AdrsWidth = 8
) (
    input  logic                 Clock,
    // Port A
    input  logic [AdrsWidth-1:0] addressA,
    input  logic [31:0]          dataA,
    input  logic                 wrEnA,
    input  logic [3:0]           byteEnA,
    output logic [31:0]          qA,
    // Port B
    input  logic [AdrsWidth-1:0] addressB,
    input  logic [31:0]          dataB,
    input  logic                 wrEnB,
    input  logic [3:0]           byteEnB,
    output logic [31:0]          qB
);

    localparam int Words = 2 ** AdrsWidth;

    logic [31:0] mem [Words];                    // Word storage

    //====================================================================
    // Write and read, both ports
    //====================================================================
    always_ff @(posedge Clock) begin
        // Byte lanes written one at a time
        for (int i = 0; i < 4; i++) begin
            if (wrEnA && byteEnA[i]) begin
                mem[addressA][8*i +: 8] <= dataA[8*i +: 8];
            end
            if (wrEnB && byteEnB[i]) begin
                mem[addressB][8*i +: 8] <= dataB[8*i +: 8];  // B wins a collision
            end
        end

        // Registered reads, old word on a same-port write
        qA <= mem[addressA];
        qB <= mem[addressB];
    end

    // Port B carries full-word fabric writes on both memories,
    // port A carries the core byte enables on the data memory

    // Same-address writes on both ports have no defined result
    sameAddrWrite: assert property (
        @(posedge Clock)
        !(wrEnA && wrEnB && (addressA == addressB) && |(byteEnA & byteEnB))
    ) else $error("dualPortRam: both ports write the same word");

endmodule

/* source/transFifo.sv */
`timescale 1ns/1ps

// Circular buffer of fabric transactions, head shown combinationally
module transFifo #(
    parameter int Depth = 4                      // Power of two, at least 2
) (
    input  logic                         Clock,
    input  logic                         reset,
    input  logic                         push,
    input  tilePkg::tTileTrans           pushData,
    input  logic                         pop,
    output tilePkg::tTileTrans           popData,
    output logic                         full,
    output logic                         empty,
    output logic [$clog2(Depth+1)-1:0]   count
);

    import tilePkg::*;

    localparam int PtrWidth   = $clog2(Depth);
    localparam int CountWidth = $clog2(Depth + 1);

    tTileTrans           storage [Depth];        // Payload, no reset
    logic [PtrWidth-1:0] wrPtr;
    logic [PtrWidth-1:0] rdPtr;
    logic                doPush;
    logic                doPop;

    //====================================================================
    // Qualified strobes
    //====================================================================
    assign doPush = push && !full;               // Overflow dropped
    assign doPop  = pop && !empty;               // Underflow ignored

    assign full    = (count == CountWidth'(Depth));
    assign empty   = (count == '0);
    assign popData = storage[rdPtr];             // Head word

    // Payload write
    always_ff @(posedge Clock) begin
        if (doPush) begin
            storage[wrPtr] <= pushData;
        end
    end

    //====================================================================
    // Pointers and occupancy
    //====================================================================
    always_ff @(posedge Clock) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) wrPtr <= wrPtr + PtrWidth'(1);   // Wraps at Depth
            if (doPop)  rdPtr <= rdPtr + PtrWidth'(1);
            case ({doPush, doPop})
                2'b10:   count <= count + CountWidth'(1);
                2'b01:   count <= count - CountWidth'(1);
                default: count <= count;         // Both or neither
            endcase
        end
    end

    // Producer must respect the full level
    noPushWhenFull: assert property (
        @(posedge Clock) disable iff (reset) !(push && full)
    ) else $error("transFifo: push while full");

    // Consumer must respect the empty level
    noPopWhenEmpty: assert property (
        @(posedge Clock) disable iff (reset) !(pop && empty)
    ) else $error("transFifo: pop while empty");

endmodule

/* source/rrArbiter.sv */
`timescale 1ns/1ps

// Two clients, one-hot grant, pointer favours last loser
module rrArbiter (
    input  logic       Clock,
    input  logic       reset,
    input  logic [1:0] request,
    output logic [1:0] grant
);

    logic priorityPtr;                           // Client tried first
    logic winnerId;                              // Index of granted client

    //====================================================================
    // Grant
    //====================================================================
    always_comb begin
        grant = 2'b00;
        if (request[priorityPtr]) begin
            grant[priorityPtr] = 1'b1;           // Preferred client
        end else if (request[~priorityPtr]) begin
            grant[~priorityPtr] = 1'b1;          // Fall back to other one
        end
    end

    assign winnerId = grant[1];

    // Move past the winner, hold when idle
    always_ff @(posedge Clock) begin
        if (reset) begin
            priorityPtr <= 1'b0;                 // Client 0 first
        end else if (|grant) begin
            priorityPtr <= ~winnerId;
        end
    end

    // Grant is one-hot or zero and only to a requester
    grantLegal: assert property (
        @(posedge Clock) disable iff (reset)
        $onehot0(grant) && ((grant & ~request) == 2'b00)
    ) else $error("rrArbiter: illegal grant");

    // A client left waiting wins the next contested cycle
    noStarvation: assert property (
        @(posedge Clock) disable iff (reset)
        (request == 2'b11) ##1 (request == 2'b11) |-> (grant != $past(grant))
    ) else $error("rrArbiter: same client granted twice in contention");

endmodule

/* source/f2cResponder.sv */
`timescale 1ns/1ps

// Fabric-to-core side, memory writes and read responses
module f2cResponder (
    input  logic                Clock,
    input  logic                reset,
    input  tilePkg::tTileId     localTileId,
    input  logic                inValid,
    input  tilePkg::tTileTrans  inTrans,
    input  logic [31:0]         iMemRdData,  // RAM port B, one cycle late
    input  logic [31:0]         dMemRdData,
    output logic                iMemWrEn,
    output logic                dMemWrEn,
    output logic                rspValid,
    output tilePkg::tTileTrans  rspTrans
);

    import tilePkg::*;

    tRegion      regionQ503H;
    logic        iMemHitQ503H;
    logic        dMemHitQ503H;
    logic        isWrQ503H;
    logic        rdStrobeQ503H;
    logic [31:0] rspAddressQ503H;

    logic        iMemHitQ504H;
    logic        dMemHitQ504H;
    logic        rdValidQ504H;
    logic [31:0] rspAddressQ504H;
    logic [31:0] rspDataQ504H;

    //====================================================================
    // Request decode, cycle 503
    //====================================================================
    assign regionQ503H   = inTrans.address[RegionMsb:RegionLsb];
    assign iMemHitQ503H  = (regionQ503H == IMemRegion);
    assign dMemHitQ503H  = (regionQ503H == DMemRegion);
    assign isWrQ503H     = inValid && (inTrans.opcode == Wr);
    assign rdStrobeQ503H = inValid && (inTrans.opcode == Rd);  // Other opcodes dropped

    // Full-word writes into the hit region
    assign iMemWrEn = isWrQ503H && iMemHitQ503H;
    assign dMemWrEn = isWrQ503H && dMemHitQ503H;

    // Response goes back to the requestor, same offset
    assign rspAddressQ503H = {inTrans.requestorId, inTrans.address[OffsetMsb:0]};

    //====================================================================
    // Align with RAM latency
    //====================================================================
    always_ff @(posedge Clock) begin
        if (reset) begin
            rdValidQ504H <= 1'b0;
        end else begin
            rdValidQ504H <= rdStrobeQ503H;
        end
    end

    // Payload side of the pipe
    always_ff @(posedge Clock) begin
        iMemHitQ504H    <= iMemHitQ503H;
        dMemHitQ504H    <= dMemHitQ503H;
        rspAddressQ504H <= rspAddressQ503H;
    end

    //====================================================================
    // Response build, cycle 504
    //====================================================================
    // Unmapped region reads back zero
    assign rspDataQ504H = iMemHitQ504H ? iMemRdData :
                          dMemHitQ504H ? dMemRdData :
                                         32'b0;

    assign rspValid             = rdValidQ504H;  // Pushed at end of 504
    assign rspTrans.address     = rspAddressQ504H;
    assign rspTrans.data        = rspDataQ504H;
    assign rspTrans.opcode      = RdRsp;
    assign rspTrans.requestorId = localTileId;   // Responder is this tile

endmodule

/* source/memWrap.sv */
`timescale 1ns/1ps

// Tile memory wrapper, core side and fabric side
module memWrap #(
    parameter int IMemAdrsWidth = 8,             // Words = 2**width
    parameter int DMemAdrsWidth = 8,
    parameter int FifoDepth     = 4
) (
    input  logic               Clock,
    input  logic               reset,
    input  tilePkg::tTileId    LocalTileId,
    // Core fetch
    input  logic [31:0]        PcQ100H,
    output logic [31:0]        PreInstructionQ101H,
    // Core loads and stores
    input  logic [31:0]        DMemAddressQ103H,
    input  logic [31:0]        DMemWrDataQ103H,
    input  logic [3:0]         DMemByteEnQ103H,
    input  logic               DMemWrEnQ103H,
    input  logic               DMemRdEnQ103H,
    output logic [31:0]        DMemRdRspQ104H,
    // Fabric in
    input  logic               InFabricValidQ503H,
    input  tilePkg::tTileTrans InFabricQ503H,
    input  logic               FabReady,
    // Levels and fabric out
    output logic               InFabricStall,
    output logic               C2fFull,
    output logic               OutFabricValidQ505H,
    output tilePkg::tTileTrans OutFabricQ505H
);

    import tilePkg::*;

    localparam int CountWidth = $clog2(FifoDepth + 1);

    logic                  f2cIMemWrEn;
    logic                  f2cDMemWrEn;
    logic [31:0]           f2cIMemRdData;
    logic [31:0]           f2cDMemRdData;
    logic                  rspValid;
    tTileTrans             rspTrans;
    tTileId                coreTileId;
    logic                  isLocalQ103H;
    logic                  localWrEnQ103H;
    logic                  remoteReqQ103H;
    tTileTrans             c2fReqQ103H;
    tTileTrans             rspHead;
    tTileTrans             reqHead;
    logic                  rspEmpty;
    logic                  reqEmpty;
    logic [CountWidth-1:0] rspCount;
    logic [CountWidth:0]   rspOccupancy;
    logic [1:0]            arbRequest;
    logic [1:0]            arbGrant;

    //====================================================================
    // Instruction memory
    //====================================================================
    dualPortRam #(.AdrsWidth(IMemAdrsWidth)) iMem (
        .Clock    (Clock),
        .addressA (PcQ100H[IMemAdrsWidth+1:2]),                    // Fetch, read only
        .dataA    (32'b0),
        .wrEnA    (1'b0),
        .byteEnA  (4'b0000),
        .qA       (PreInstructionQ101H),
        .addressB (InFabricQ503H.address[IMemAdrsWidth+1:2]),      // Fabric side
        .dataB    (InFabricQ503H.data),
        .wrEnB    (f2cIMemWrEn),
        .byteEnB  (4'b1111),
        .qB       (f2cIMemRdData)
    );

    //====================================================================
    // Data memory and local/remote split
    //====================================================================
    assign coreTileId     = DMemAddressQ103H[TileIdMsb:TileIdLsb];
    assign isLocalQ103H   = (coreTileId == LocalTileId) || (coreTileId == '0);
    assign localWrEnQ103H = DMemWrEnQ103H && isLocalQ103H;
    assign remoteReqQ103H = (DMemWrEnQ103H || DMemRdEnQ103H) && !isLocalQ103H;

    dualPortRam #(.AdrsWidth(DMemAdrsWidth)) dMem (
        .Clock    (Clock),
        .addressA (DMemAddressQ103H[DMemAdrsWidth+1:2]),           // Core side
        .dataA    (DMemWrDataQ103H),
        .wrEnA    (localWrEnQ103H),
        .byteEnA  (DMemByteEnQ103H),
        .qA       (DMemRdRspQ104H),
        .addressB (InFabricQ503H.address[DMemAdrsWidth+1:2]),
        .dataB    (InFabricQ503H.data),
        .wrEnB    (f2cDMemWrEn),
        .byteEnB  (4'b1111),
        .qB       (f2cDMemRdData)
    );

    f2cResponder f2cResp (
        .Clock       (Clock),
        .reset       (reset),
        .localTileId (LocalTileId),
        .inValid     (InFabricValidQ503H),
        .inTrans     (InFabricQ503H),
        .iMemRdData  (f2cIMemRdData),
        .dMemRdData  (f2cDMemRdData),
        .iMemWrEn    (f2cIMemWrEn),
        .dMemWrEn    (f2cDMemWrEn),
        .rspValid    (rspValid),
        .rspTrans    (rspTrans)
    );

    // Remote access as one fabric transaction
    assign c2fReqQ103H.address     = DMemAddressQ103H;
    assign c2fReqQ103H.data        = DMemWrDataQ103H;
    assign c2fReqQ103H.opcode      = DMemWrEnQ103H ? Wr : Rd;     // Write wins
    assign c2fReqQ103H.requestorId = LocalTileId;

    //====================================================================
    // Outgoing queues, arbitration and output mux
    //====================================================================
    transFifo #(.Depth(FifoDepth)) rspFifo (
        .Clock    (Clock),
        .reset    (reset),
        .push     (rspValid),
        .pushData (rspTrans),
        .pop      (arbGrant[0]),
        .popData  (rspHead),
        .full     (),                            // Stall level used instead
        .empty    (rspEmpty),
        .count    (rspCount)
    );

    transFifo #(.Depth(FifoDepth)) reqFifo (
        .Clock    (Clock),
        .reset    (reset),
        .push     (remoteReqQ103H),
        .pushData (c2fReqQ103H),
        .pop      (arbGrant[1]),
        .popData  (reqHead),
        .full     (C2fFull),
        .empty    (reqEmpty),
        .count    ()
    );

    // Queued plus the one response still in the responder
    assign rspOccupancy  = {1'b0, rspCount} + {{CountWidth{1'b0}}, rspValid};
    assign InFabricStall = (rspOccupancy >= (CountWidth + 1)'(FifoDepth));

    // Nothing competes while the fabric is not ready
    assign arbRequest = {!reqEmpty && FabReady, !rspEmpty && FabReady};

    rrArbiter outArbiter (
        .Clock   (Clock),
        .reset   (reset),
        .request (arbRequest),
        .grant   (arbGrant)
    );

    assign OutFabricValidQ505H = |arbGrant;
    assign OutFabricQ505H      = arbGrant[0] ? rspHead :
                                 arbGrant[1] ? reqHead :
                                               '0;

    // Core holds remote accesses while the request queue is full
    coreRespectsFull: assert property (
        @(posedge Clock) disable iff (reset) remoteReqQ103H |-> !C2fFull
    ) else $error("memWrap: remote access while C2fFull");

    // Fabric holds reads while stalled
    fabricRespectsStall: assert property (
        @(posedge Clock) disable iff (reset)
        (InFabricValidQ503H && (InFabricQ503H.opcode == Rd)) |-> !InFabricStall
    ) else $error("memWrap: fabric read while InFabricStall");

endmodule

/* test/memWrapTb.sv */
`timescale 1ns/1ps

module memWrapTb;

    import tilePkg::*;

    localparam int     Depth     = 4;          // Matches memWrap default
    localparam int     MaxCycles = 2000;       // Tests need about 300 cycles
    localparam tTileId MyTile    = 8'h05;

    logic        Clock;
    logic        reset;
    logic [31:0] PcQ100H;
    logic [31:0] PreInstructionQ101H;
    logic [31:0] DMemAddressQ103H;
    logic [31:0] DMemWrDataQ103H;
    logic [3:0]  DMemByteEnQ103H;
    logic        DMemWrEnQ103H;
    logic        DMemRdEnQ103H;
    logic [31:0] DMemRdRspQ104H;
    logic        InFabricValidQ503H;
    tTileTrans   InFabricQ503H;
    logic        FabReady;
    logic        InFabricStall;
    logic        C2fFull;
    logic        OutFabricValidQ505H;
    tTileTrans   OutFabricQ505H;

    tTileTrans   outQ [$];                     // Seen on the fabric output
    tTileTrans   expRsp [$];                   // Expected read responses
    tTileTrans   expReq [$];                   // Expected core requests
    logic [31:0] iModel [256];
    logic [31:0] dModel [256];
    int          errors;
    int          testsRun;
    int          testsFailed;
    int          cycles;

    memWrap i_memWrap (
        .Clock               (Clock),
        .reset               (reset),
        .LocalTileId         (MyTile),
        .PcQ100H             (PcQ100H),
        .PreInstructionQ101H (PreInstructionQ101H),
        .DMemAddressQ103H    (DMemAddressQ103H),
        .DMemWrDataQ103H     (DMemWrDataQ103H),
        .DMemByteEnQ103H     (DMemByteEnQ103H),
        .DMemWrEnQ103H       (DMemWrEnQ103H),
        .DMemRdEnQ103H       (DMemRdEnQ103H),
        .DMemRdRspQ104H      (DMemRdRspQ104H),
        .InFabricValidQ503H  (InFabricValidQ503H),
        .InFabricQ503H       (InFabricQ503H),
        .FabReady            (FabReady),
        .InFabricStall       (InFabricStall),
        .C2fFull             (C2fFull),
        .OutFabricValidQ505H (OutFabricValidQ505H),
        .OutFabricQ505H      (OutFabricQ505H)
    );

    //======================================================================
    // Clock, cycle limit, output monitor
    //======================================================================
    initial begin
        Clock = 1'b0;
        forever #50 Clock = ~Clock;            // 100 ns period
    end

    always @(posedge Clock) begin
        cycles++;
        if (cycles >= MaxCycles) begin
            $display("Run stopped, cycle limit of %0d reached", MaxCycles);
            $display("Some tests failed");
            $finish;
        end
    end

    // Sample just before the rising edge, inputs long settled
    initial begin
        forever begin
            @(negedge Clock);
            #45;
            if (OutFabricValidQ505H === 1'b1) outQ.push_back(OutFabricQ505H);
        end
    end

    //======================================================================
    // Helpers
    //======================================================================
    function automatic tTileTrans makeTrans(input logic [31:0] address,
                                            input logic [31:0] data,
                                            input tOpcode opcode,
                                            input tTileId requestorId);
        tTileTrans t;
        t.address     = address;
        t.data        = data;
        t.opcode      = opcode;
        t.requestorId = requestorId;
        return t;
    endfunction

    // {tile, region, word index}
    function automatic logic [31:0] fabAdrs(input tRegion region, input int idx);
        return {MyTile, region, 12'b0, idx[7:0], 2'b00};
    endfunction

    function automatic logic [31:0] coreAdrs(input tTileId tile, input int idx);
        return {tile, 14'b0, idx[7:0], 2'b00};
    endfunction

    task automatic checkWord(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic checkTrans(input tTileTrans got, input tTileTrans exp);
        if (got !== exp) begin
            $display("CHECK FAILED OutFabricQ505H got %h expected %h", got, exp);
            errors++;
        end
    endtask

    task automatic reportError(input string what);
        $display("ERROR %s", what);
        errors++;
    endtask

    // One fabric transaction, held back while a read would overflow
    task automatic fabricSend(input tOpcode op, input logic [31:0] addr,
                              input logic [31:0] data, input tTileId reqId);
        @(negedge Clock);
        DMemWrEnQ103H = 1'b0;
        DMemRdEnQ103H = 1'b0;
        while (op == Rd && InFabricStall) begin
            InFabricValidQ503H = 1'b0;
            @(negedge Clock);
        end
        InFabricValidQ503H = 1'b1;
        InFabricQ503H      = makeTrans(addr, data, op, reqId);
    endtask

    task automatic coreAccess(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] be, input logic we, input logic re);
        @(negedge Clock);
        InFabricValidQ503H = 1'b0;
        DMemAddressQ103H   = addr;
        DMemWrDataQ103H    = data;
        DMemByteEnQ103H    = be;
        DMemWrEnQ103H      = we;
        DMemRdEnQ103H      = re;
    endtask

    task automatic releaseInputs();
        @(negedge Clock);
        InFabricValidQ503H = 1'b0;
        DMemWrEnQ103H      = 1'b0;
        DMemRdEnQ103H      = 1'b0;
    endtask

    task automatic localRead(input logic [31:0] addr, input logic [31:0] exp);
        coreAccess(addr, 32'h0, 4'h0, 1'b0, 1'b1);
        @(negedge Clock);
        DMemRdEnQ103H = 1'b0;
        checkWord("DMemRdRspQ104H", DMemRdRspQ104H, exp);  // One cycle later
    endtask

    task automatic waitForOutputs(input int n);
        int waited;
        waited = 0;
        while (outQ.size() < n && waited < 50) begin
            @(negedge Clock);
            waited++;
        end
        if (outQ.size() < n) begin
            reportError($sformatf("only %0d of %0d outputs arrived", outQ.size(), n));
        end
    endtask

    // In-order per queue, alternating while both have entries
    task automatic matchOutputs();
        tTileTrans got;
        int        total;
        bit        isRsp;
        bit        lastWasRsp;
        lastWasRsp = 1'b0;
        total      = expRsp.size() + expReq.size();
        waitForOutputs(total);
        for (int n = 0; n < total && outQ.size() > 0; n++) begin
            got   = outQ.pop_front();
            isRsp = (got.opcode == RdRsp);
            if (n > 0 && isRsp == lastWasRsp &&
                ((isRsp && expReq.size() > 0) || (!isRsp && expRsp.size() > 0))) begin
                reportError("same queue served twice while the other was waiting");
            end
            if (isRsp && expRsp.size() > 0) checkTrans(got, expRsp.pop_front());
            else if (!isRsp && expReq.size() > 0) checkTrans(got, expReq.pop_front());
            else reportError("output with no matching expected transaction");
            lastWasRsp = isRsp;
        end
        expRsp.delete();
        expReq.delete();
        repeat (3) @(negedge Clock);
        if (outQ.size() != 0) reportError("extra transaction on the fabric output");
        outQ.delete();
    endtask

    task automatic finishTest(input string name, input int errBefore);
        testsRun++;
        if (errors == errBefore) begin
            $display("PASS  %s", name);
        end else begin
            testsFailed++;
            $display("FAIL  %s, %0d errors", name, errors - errBefore);
        end
    endtask

    //======================================================================
    // Tests
    //======================================================================
    task automatic fetchAfterFabricWrite();
        int          idx;
        logic [31:0] word;
        for (int i = 0; i < 8; i++) begin
            idx         = i * 5 + 1;
            word        = $urandom;
            iModel[idx] = word;
            fabricSend(Wr, fabAdrs(IMemRegion, idx), word, 8'h21);
        end
        releaseInputs();
        for (int i = 0; i < 8; i++) begin
            idx = i * 5 + 1;
            @(negedge Clock);
            PcQ100H = {22'b0, idx[7:0], 2'b00};
            @(negedge Clock);
            checkWord("PreInstructionQ101H", PreInstructionQ101H, iModel[idx]);
        end
    endtask

    task automatic localDataAccess();
        int          idx;
        logic [31:0] word;
        logic [3:0]  be;
        tTileId      tile;
        for (int i = 0; i < 8; i++) begin
            idx         = i * 3 + 2;
            tile        = (i % 2 == 0) ? MyTile : 8'h00;   // Own id or zero
            word        = $urandom;
            dModel[idx] = word;
            coreAccess(coreAdrs(tile, idx), word, 4'hF, 1'b1, 1'b0);
            word = $urandom;
            be   = 4'($urandom);
            for (int b = 0; b < 4; b++) begin
                if (be[b]) dModel[idx][8*b +: 8] = word[8*b +: 8];  // Byte merge
            end
            coreAccess(coreAdrs(tile, idx), word, be, 1'b1, 1'b0);
            localRead(coreAdrs(tile, idx), dModel[idx]);
        end
        // Fabric write seen by the core
        for (int i = 0; i < 4; i++) begin
            idx         = i * 3 + 2;
            word        = $urandom;
            dModel[idx] = word;
            fabricSend(Wr, fabAdrs(DMemRegion, idx), word, 8'h21);
            localRead(coreAdrs(MyTile, idx), word);
        end
    endtask

    task automatic fabricReadResponses();
        logic [31:0] addr;
        tTileId      reqId;
        FabReady = 1'b1;
        for (int i = 0; i < 10; i++) begin
            reqId = 8'h30 + 8'(i);
            if (i < 4) begin
                addr = fabAdrs(IMemRegion, i * 5 + 1);
                expRsp.push_back(makeTrans({reqId, addr[23:0]}, iModel[i * 5 + 1],
                                           RdRsp, MyTile));
            end else if (i < 8) begin
                addr = fabAdrs(DMemRegion, (i - 4) * 3 + 2);
                expRsp.push_back(makeTrans({reqId, addr[23:0]}, dModel[(i - 4) * 3 + 2],
                                           RdRsp, MyTile));
            end else begin
                addr = fabAdrs(tRegion'(i - 6), i);                 // Regions 2 and 3
                expRsp.push_back(makeTrans({reqId, addr[23:0]}, 32'h0, RdRsp, MyTile));
            end
            fabricSend(Rd, addr, $urandom, reqId);
        end
        releaseInputs();
        matchOutputs();
    endtask

    task automatic remoteBackPressure();
        logic [31:0] addr;
        logic [31:0] word;
        logic        we;
        FabReady = 1'b0;
        for (int i = 0; i < Depth; i++) begin
            addr = {8'h0A, 24'($urandom)};
            word = $urandom;
            we   = i[0];
            coreAccess(addr, word, 4'hF, we, !we);
            checkWord("C2fFull", 32'(C2fFull), 32'h0);
            expReq.push_back(makeTrans(addr, word, we ? Wr : Rd, MyTile));
        end
        releaseInputs();
        checkWord("C2fFull", 32'(C2fFull), 32'h1);
        repeat (3) @(negedge Clock);
        if (outQ.size() != 0) reportError("output shown while FabReady was low");
        FabReady = 1'b1;
        matchOutputs();
        checkWord("C2fFull", 32'(C2fFull), 32'h0);
    endtask

    task automatic mixedArbitration();
        logic [31:0] addr;
        logic [31:0] word;
        FabReady = 1'b0;
        for (int i = 0; i < Depth; i++) begin
            addr = fabAdrs(DMemRegion, i * 3 + 2);
            expRsp.push_back(makeTrans({8'h40, addr[23:0]}, dModel[i * 3 + 2],
                                       RdRsp, MyTile));
            fabricSend(Rd, addr, 32'h0, 8'h40);
        end
        for (int i = 0; i < Depth; i++) begin
            addr = {8'h0B, 24'($urandom)};
            word = $urandom;
            coreAccess(addr, word, 4'hF, 1'b1, 1'b0);
            expReq.push_back(makeTrans(addr, word, Wr, MyTile));
        end
        releaseInputs();
        checkWord("InFabricStall", 32'(InFabricStall), 32'h1);   // Both queues full
        checkWord("C2fFull", 32'(C2fFull), 32'h1);
        FabReady = 1'b1;
        matchOutputs();
        checkWord("InFabricStall", 32'(InFabricStall), 32'h0);
        checkWord("C2fFull", 32'(C2fFull), 32'h0);
    endtask

    task automatic resetMidTraffic();
        FabReady = 1'b0;
        for (int i = 0; i < Depth; i++) begin
            fabricSend(Rd, fabAdrs(DMemRegion, i * 3 + 2), 32'h0, 8'h50);
        end
        for (int i = 0; i < Depth; i++) begin
            coreAccess({8'h0C, 24'(16 * (i + 1))}, $urandom, 4'hF, i[0], !i[0]);
        end
        releaseInputs();
        reset = 1'b1;                          // Both queues full here
        repeat (2) @(negedge Clock);
        reset    = 1'b0;
        FabReady = 1'b1;
        @(negedge Clock);
        checkWord("OutFabricValidQ505H", 32'(OutFabricValidQ505H), 32'h0);
        checkWord("InFabricStall", 32'(InFabricStall), 32'h0);
        checkWord("C2fFull", 32'(C2fFull), 32'h0);
        repeat (5) @(negedge Clock);
        if (outQ.size() != 0) reportError("stale transaction shown after reset");
        outQ.delete();
    endtask

    //======================================================================
    // Sequence
    //======================================================================
    initial begin
        int startErrors;
        void'($urandom(32'hbd58));
        errors             = 0;
        testsRun           = 0;
        testsFailed        = 0;
        cycles             = 0;
        reset              = 1'b1;
        PcQ100H            = 32'h0;
        DMemAddressQ103H   = 32'h0;
        DMemWrDataQ103H    = 32'h0;
        DMemByteEnQ103H    = 4'h0;
        DMemWrEnQ103H      = 1'b0;
        DMemRdEnQ103H      = 1'b0;
        InFabricValidQ503H = 1'b0;
        InFabricQ503H      = '0;
        FabReady           = 1'b0;
        repeat (2) @(posedge Clock);           // Two rising edges in reset
        @(negedge Clock);
        reset = 1'b0;

        startErrors = errors;
        fetchAfterFabricWrite();
        finishTest("IMem fetch after fabric write", startErrors);
        startErrors = errors;
        localDataAccess();
        finishTest("local data access", startErrors);
        startErrors = errors;
        fabricReadResponses();
        finishTest("fabric read responses", startErrors);
        startErrors = errors;
        remoteBackPressure();
        finishTest("remote requests under back-pressure", startErrors);
        startErrors = errors;
        mixedArbitration();
        finishTest("response and request arbitration", startErrors);
        startErrors = errors;
        resetMidTraffic();
        finishTest("reset in mid traffic", startErrors);

        $display("Ran %0d, %0d with errors, %0d check errors", testsRun, testsFailed, errors);
        if (errors == 0 && testsFailed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* sources.f */
source/tilePkg.sv
source/dualPortRam.sv
source/transFifo.sv
source/rrArbiter.sv
source/f2cResponder.sv
source/memWrap.sv
test/memWrapTb.sv

/* Makefile */
TOP = memWrapTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^All tests passed$$"

clean:
	rm -rf obj_dir
